// ==== csr_pkg.sv ====
`include "trap_config.svh"

package csr_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [11:0]      csr_addr_t;

    // sw, timer, ext enables in irq vector order
    typedef logic [2:0] mie_bits_t;

    // machine csr addresses
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;

    // bit positions shared by mie and mip
    localparam int MIX_MSI = 3;
    localparam int MIX_MTI = 7;
    localparam int MIX_MEI = 11;

    typedef struct packed {
        logic      ren;
        logic      wen;
        csr_addr_t raddr;
        csr_addr_t waddr;
        xlen_t     wdata;
    } csr_req_t;

    typedef struct packed {
        logic      mstatus_mie;
        mie_bits_t mie_bits;
        xlen_t     mtvec_base;
        xlen_t     mepc;
    } csr_view_t;

endpackage

// ==== csr_regs.sv ====
`include "trap_config.svh"

module csr_regs
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  csr_req_t     csr_req,
    input  irq_vec_t     mip_bits,
    input  trap_update_t trap_update,
    output xlen_t        csr_rdata,
    output csr_view_t    csr_view
);

    localparam xlen_t MISA_VALUE = `MISA_RESET;

    xlen_t mstatus;
    xlen_t mie;
    xlen_t mtvec;
    xlen_t mscratch;
    xlen_t mepc;
    xlen_t mcause;
    xlen_t mtval;

    xlen_t mip_word;
    xlen_t mstatus_trap;
    xlen_t read_value;
    logic  read_bypass;

    // pending lines placed at their mip bit positions
    always_comb begin
        mip_word = '0;
        mip_word[MIX_MSI] = mip_bits[IRQ_SW];
        mip_word[MIX_MTI] = mip_bits[IRQ_TIMER];
        mip_word[MIX_MEI] = mip_bits[IRQ_EXT];
    end

    // interrupt enable stack, push on take and pop on mret
    always_comb begin
        mstatus_trap = mstatus;
        if (trap_update.take) begin
            mstatus_trap[MSTATUS_MPIE] = mstatus[MSTATUS_MIE];
            mstatus_trap[MSTATUS_MIE] = 1'b0;
        end else begin
            mstatus_trap[MSTATUS_MIE] = mstatus[MSTATUS_MPIE];
            mstatus_trap[MSTATUS_MPIE] = 1'b1;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            mstatus <= '0;
            mie <= '0;
            mtvec <= '0;
            mscratch <= '0;
            mepc <= '0;
            mcause <= '0;
            mtval <= '0;
        end else begin
            if (csr_req.wen) begin
                case (csr_req.waddr)
                    CSR_MSTATUS:  mstatus <= csr_req.wdata;
                    CSR_MIE:      mie <= csr_req.wdata;
                    CSR_MTVEC:    mtvec <= {csr_req.wdata[`XLEN-1:2], 2'b00};
                    CSR_MSCRATCH: mscratch <= csr_req.wdata;
                    CSR_MEPC:     mepc <= csr_req.wdata;
                    CSR_MCAUSE:   mcause <= csr_req.wdata;
                    CSR_MTVAL:    mtval <= csr_req.wdata;
                    default: ;
                endcase
            end
            // trap side comes last so it overrides a core write in the same cycle
            if (trap_update.take) begin
                mepc <= trap_update.epc;
                mcause <= trap_update.cause;
                mtval <= '0;
                mstatus <= mstatus_trap;
            end else if (trap_update.ret) begin
                mstatus <= mstatus_trap;
            end
        end
    end

    always_comb begin
        case (csr_req.raddr)
            CSR_MSTATUS:  read_value = mstatus;
            CSR_MISA:     read_value = MISA_VALUE;
            CSR_MIE:      read_value = mie;
            CSR_MTVEC:    read_value = mtvec;
            CSR_MSCRATCH: read_value = mscratch;
            CSR_MEPC:     read_value = mepc;
            CSR_MCAUSE:   read_value = mcause;
            CSR_MTVAL:    read_value = mtval;
            CSR_MIP:      read_value = mip_word;
            default:      read_value = '0;
        endcase
    end

    assign read_bypass = csr_req.wen && (csr_req.waddr == csr_req.raddr);

    // registered read port, holds between reads
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            csr_rdata <= '0;
        end else if (csr_req.ren) begin
            csr_rdata <= read_bypass ? csr_req.wdata : read_value;
        end
    end

    assign csr_view.mstatus_mie = mstatus[MSTATUS_MIE];
    assign csr_view.mie_bits = {mie[MIX_MEI], mie[MIX_MTI], mie[MIX_MSI]};
    assign csr_view.mtvec_base = mtvec;
    assign csr_view.mepc = mepc;

endmodule

// ==== irq_sync_arbiter.sv ====
`include "trap_config.svh"

module irq_sync_arbiter
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  irq_vec_t  irq_lines,
    input  csr_view_t csr_view,
    output irq_vec_t  mip_bits,
    output irq_req_t  irq_req
);

    irq_vec_t sync_q [`IRQ_SYNC_STAGES];
    irq_vec_t irq_masked;

    // one synchronizer chain per line, all three shifted together
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < `IRQ_SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= irq_lines;
            for (int i = 1; i < `IRQ_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign mip_bits = sync_q[`IRQ_SYNC_STAGES-1];

    // per-line enable plus the global MIE
    assign irq_masked = mip_bits & csr_view.mie_bits & {3{csr_view.mstatus_mie}};

    // fixed rank: external, software, timer
    always_comb begin
        irq_req.valid = 1'b0;
        irq_req.cause = '0;
        if (irq_masked[IRQ_EXT]) begin
            irq_req.valid = 1'b1;
            irq_req.cause = CAUSE_IRQ_EXT;
        end else if (irq_masked[IRQ_SW]) begin
            irq_req.valid = 1'b1;
            irq_req.cause = CAUSE_IRQ_SW;
        end else if (irq_masked[IRQ_TIMER]) begin
            irq_req.valid = 1'b1;
            irq_req.cause = CAUSE_IRQ_TIMER;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the trap unit testbench with Verilator
cd "$(dirname "$0")" && \
verilator --binary --timing --assert -f sim.f --top-module tb_trap_unit -o tb_trap_unit && \
./obj_dir/tb_trap_unit | tee /dev/stderr | grep -q "^Test OK$" && \
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+.
csr_pkg.sv
trap_pkg.sv
csr_regs.sv
irq_sync_arbiter.sv
trap_ctrl.sv
trap_unit.sv
trap_unit_assert.sv
tb_trap_unit.sv

// ==== tb_trap_unit.sv ====
`include "trap_config.svh"

module tb_trap_unit
    import csr_pkg::*;
    import trap_pkg::*;
();

    localparam int NUM_OPS = 600;
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int STAGES = `IRQ_SYNC_STAGES;

    logic      clock;
    logic      reset;
    csr_req_t  csr_req;
    xlen_t     csr_rdata;
    sys_op_t   sys_op;
    xlen_t     pc;
    irq_vec_t  irq_lines;
    logic      pc_written;
    logic      trap_pending;
    logic      redirect_is_irq;
    xlen_t     redirect_vector;

    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    // reference model state
    xlen_t     m_mstatus;
    xlen_t     m_mie;
    xlen_t     m_mtvec;
    xlen_t     m_mscratch;
    xlen_t     m_mepc;
    xlen_t     m_mcause;
    xlen_t     m_mtval;
    xlen_t     m_rdata;
    xlen_t     m_vector;
    logic      m_pending;
    logic      m_is_irq;
    irq_vec_t  m_sync [STAGES];
    csr_addr_t m_last_raddr;

    trap_unit dut (
        .clock           (clock),
        .reset           (reset),
        .csr_req         (csr_req),
        .csr_rdata       (csr_rdata),
        .sys_op          (sys_op),
        .pc              (pc),
        .irq_lines       (irq_lines),
        .pc_written      (pc_written),
        .trap_pending    (trap_pending),
        .redirect_is_irq (redirect_is_irq),
        .redirect_vector (redirect_vector)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // galois lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic xlen_t rand_bits(input int count);
        xlen_t result;
        result = '0;
        for (int i = 0; i < count; i++) begin
            result = {result[30:0], lfsr_bit()};
        end
        return result;
    endfunction

    // nine machine csrs plus one address that does not exist
    function automatic csr_addr_t pick_addr(input int sel);
        case (sel % 10)
            0: return 12'h300;
            1: return 12'h301;
            2: return 12'h304;
            3: return 12'h305;
            4: return 12'h340;
            5: return 12'h341;
            6: return 12'h342;
            7: return 12'h343;
            8: return 12'h344;
            default: return 12'h7c0;
        endcase
    endfunction

    function automatic xlen_t model_read(input csr_addr_t addr);
        xlen_t mip_word;
        mip_word = '0;
        mip_word[3] = m_sync[STAGES-1][0];
        mip_word[7] = m_sync[STAGES-1][1];
        mip_word[11] = m_sync[STAGES-1][2];
        case (addr)
            12'h300: return m_mstatus;
            12'h301: return `MISA_RESET;
            12'h304: return m_mie;
            12'h305: return m_mtvec;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h343: return m_mtval;
            12'h344: return mip_word;
            default: return '0;
        endcase
    endfunction

    task automatic check_data(input xlen_t got, input xlen_t expected, input string what);
        if (got !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1, "data mismatch on %s", what);
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("error at time %0t: %s is %b, expected %b", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1, "flag mismatch on %s", what);
        end
    endtask

    task automatic check_cause(input cause_t got, input cause_t expected, input string what);
        if (got !== expected) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1, "cause mismatch on %s", what);
        end
    endtask

    task automatic model_reset();
        m_mstatus = '0;
        m_mie = '0;
        m_mtvec = '0;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_mtval = '0;
        m_rdata = '0;
        m_vector = '0;
        m_pending = 1'b0;
        m_is_irq = 1'b0;
        m_last_raddr = '0;
        for (int i = 0; i < STAGES; i++) begin
            m_sync[i] = '0;
        end
    endtask

    // advance the model by one rising edge with the inputs now driven
    task automatic model_step();
        irq_vec_t masked;
        xlen_t    irq_cause;
        xlen_t    old_mstatus;
        xlen_t    old_mtvec;
        xlen_t    old_mepc;
        logic     do_trap;
        logic     do_ret;
        logic     do_irq;
        masked = m_sync[STAGES-1] & {m_mie[11], m_mie[7], m_mie[3]} & {3{m_mstatus[3]}};
        irq_cause = '0;
        if (masked[2]) begin
            irq_cause = 32'h8000_000b;
        end else if (masked[0]) begin
            irq_cause = 32'h8000_0003;
        end else if (masked[1]) begin
            irq_cause = 32'h8000_0007;
        end
        do_trap = !m_pending && (sys_op == SYS_ECALL || sys_op == SYS_EBREAK);
        do_ret = !m_pending && (sys_op == SYS_MRET);
        do_irq = !m_pending && (sys_op == SYS_NONE) && (masked != 3'b000);
        old_mstatus = m_mstatus;
        old_mtvec = m_mtvec;
        old_mepc = m_mepc;
        if (csr_req.ren) begin
            if (csr_req.wen && csr_req.waddr == csr_req.raddr) begin
                m_rdata = csr_req.wdata;
            end else begin
                m_rdata = model_read(csr_req.raddr);
            end
            m_last_raddr = csr_req.raddr;
        end
        if (csr_req.wen) begin
            case (csr_req.waddr)
                12'h300: m_mstatus = csr_req.wdata;
                12'h304: m_mie = csr_req.wdata;
                12'h305: m_mtvec = csr_req.wdata & 32'hffff_fffc;
                12'h340: m_mscratch = csr_req.wdata;
                12'h341: m_mepc = csr_req.wdata;
                12'h342: m_mcause = csr_req.wdata;
                12'h343: m_mtval = csr_req.wdata;
                default: ;
            endcase
        end
        // redirect targets come from the csrs before this edge
        if (do_trap || do_irq) begin
            m_mepc = pc;
            if (do_irq) begin
                m_mcause = irq_cause;
            end else if (sys_op == SYS_ECALL) begin
                m_mcause = 32'd11;
            end else begin
                m_mcause = 32'd3;
            end
            m_mtval = '0;
            m_mstatus = old_mstatus;
            m_mstatus[7] = old_mstatus[3];
            m_mstatus[3] = 1'b0;
            m_vector = old_mtvec;
            m_is_irq = do_irq;
            m_pending = 1'b1;
        end else if (do_ret) begin
            m_mstatus = old_mstatus;
            m_mstatus[3] = old_mstatus[7];
            m_mstatus[7] = 1'b1;
            m_vector = old_mepc;
            m_is_irq = 1'b0;
            m_pending = 1'b1;
        end else if (m_pending && pc_written) begin
            m_pending = 1'b0;
            m_is_irq = 1'b0;
        end
        for (int i = STAGES - 1; i > 0; i--) begin
            m_sync[i] = m_sync[i-1];
        end
        m_sync[0] = irq_lines;
    endtask

    task automatic compare_outputs();
        if (m_last_raddr == 12'h342) begin
            check_cause(csr_rdata, m_rdata, "csr_rdata from mcause");
        end else begin
            check_data(csr_rdata, m_rdata, "csr_rdata");
        end
        check_flag(trap_pending, m_pending, "trap_pending");
        check_flag(redirect_is_irq, m_is_irq, "redirect_is_irq");
        check_data(redirect_vector, m_vector, "redirect_vector");
    endtask

    // one rising edge, then compare on the following falling edge
    task automatic step_and_check();
        model_step();
        @(negedge clock);
        compare_outputs();
    endtask

    // random csr access, sys op and interrupt lines for one cycle
    task automatic drive_random();
        csr_req.ren = lfsr_bit();
        csr_req.wen = lfsr_bit() & lfsr_bit();
        csr_req.raddr = pick_addr(rand_bits(5));
        if (lfsr_bit()) begin
            csr_req.waddr = csr_req.raddr;
        end else begin
            csr_req.waddr = pick_addr(rand_bits(5));
        end
        csr_req.wdata = rand_bits(32);
        pc_written = lfsr_bit() & lfsr_bit();
        pc = rand_bits(32) & 32'hffff_fffc;
        // the core issues no sys op while a trap is pending
        if (!m_pending && rand_bits(3) == 0) begin
            case (rand_bits(2))
                0: sys_op = SYS_ECALL;
                1: sys_op = SYS_EBREAK;
                2: sys_op = SYS_MRET;
                default: sys_op = SYS_ECALL;
            endcase
        end else begin
            sys_op = SYS_NONE;
        end
        if (rand_bits(2) == 0) begin
            irq_lines = irq_vec_t'(rand_bits(3));
        end
    endtask

    task automatic drive_quiet();
        csr_req.ren = 1'b0;
        csr_req.wen = 1'b0;
        sys_op = SYS_NONE;
        pc_written = lfsr_bit() & lfsr_bit();
    endtask

    initial begin
        int quiet_cycles;
        lfsr_state = 32'd54;
        reset = 1'b0;
        csr_req = '0;
        sys_op = SYS_NONE;
        pc = '0;
        irq_lines = '0;
        pc_written = 1'b0;
        model_reset();
        repeat (8) @(negedge clock);
        compare_outputs();
        reset = 1'b1;
        for (int op = 0; op < NUM_OPS; op++) begin
            drive_random();
            step_and_check();
            quiet_cycles = int'(rand_bits(2));
            for (int i = 0; i < quiet_cycles; i++) begin
                drive_quiet();
                step_and_check();
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

// ==== trap_config.svh ====
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// register width of the core
`define XLEN 32

// misa for RV32I: MXL = 1 in the top two bits, I extension at bit 8
`define MISA_RESET 32'h4000_0100

// flops per interrupt synchronizer, 2 or 3
`define IRQ_SYNC_STAGES 2

`endif

// ==== trap_ctrl.sv ====
module trap_ctrl
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  sys_op_t      sys_op,
    input  xlen_t        pc,
    input  irq_req_t     irq_req,
    input  csr_view_t    csr_view,
    input  logic         pc_written,
    output trap_update_t trap_update,
    output logic         trap_pending,
    output logic         redirect_is_irq,
    output xlen_t        redirect_vector
);

    trap_state_t state_q;
    trap_state_t state_d;

    logic is_idle;
    logic sys_trap;
    logic sys_ret;
    logic irq_take;

    assign is_idle = (state_q == TRAP_IDLE);

    // a system op always beats an interrupt in the same cycle
    always_comb begin
        sys_trap = is_idle && (sys_op == SYS_ECALL || sys_op == SYS_EBREAK);
        sys_ret = is_idle && (sys_op == SYS_MRET);
        irq_take = is_idle && (sys_op == SYS_NONE) && irq_req.valid;
    end

    // strobes to the csr block, live only in the accepting cycle
    always_comb begin
        trap_update.take = sys_trap || irq_take;
        trap_update.ret = sys_ret;
        trap_update.epc = pc;
        case (sys_op)
            SYS_ECALL:  trap_update.cause = CAUSE_ECALL_M;
            SYS_EBREAK: trap_update.cause = CAUSE_BREAKPOINT;
            SYS_NONE:   trap_update.cause = irq_req.cause;
            default:    trap_update.cause = '0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRAP_IDLE: begin
                if (sys_trap || sys_ret || irq_take) begin
                    state_d = TRAP_PENDING;
                end
            end
            TRAP_PENDING: begin
                // core has loaded the new pc
                if (pc_written) begin
                    state_d = TRAP_IDLE;
                end
            end
            default: state_d = TRAP_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q <= TRAP_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // redirect target and source, held until the next accept
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            redirect_vector <= '0;
            redirect_is_irq <= 1'b0;
        end else if (sys_ret) begin
            redirect_vector <= csr_view.mepc;
            redirect_is_irq <= 1'b0;
        end else if (sys_trap || irq_take) begin
            redirect_vector <= csr_view.mtvec_base;
            redirect_is_irq <= irq_take;
        end else if (!is_idle && pc_written) begin
            redirect_is_irq <= 1'b0;
        end
    end

    assign trap_pending = (state_q == TRAP_PENDING);

endmodule

// ==== trap_pkg.sv ====
package trap_pkg;
    import csr_pkg::*;

    typedef enum logic [1:0] {
        SYS_NONE,
        SYS_ECALL,
        SYS_EBREAK,
        SYS_MRET
    } sys_op_t;

    typedef xlen_t cause_t;

    // bit 0 software, bit 1 timer, bit 2 external
    typedef logic [2:0] irq_vec_t;

    localparam int IRQ_SW    = 0;
    localparam int IRQ_TIMER = 1;
    localparam int IRQ_EXT   = 2;

    // exception causes keep the top bit clear
    localparam cause_t CAUSE_BREAKPOINT = cause_t'(3);
    localparam cause_t CAUSE_ECALL_M    = cause_t'(11);

    localparam cause_t CAUSE_IRQ_FLAG = cause_t'(1) << ($bits(cause_t) - 1);
    localparam cause_t CAUSE_IRQ_SW    = CAUSE_IRQ_FLAG | cause_t'(3);
    localparam cause_t CAUSE_IRQ_TIMER = CAUSE_IRQ_FLAG | cause_t'(7);
    localparam cause_t CAUSE_IRQ_EXT   = CAUSE_IRQ_FLAG | cause_t'(11);

    typedef struct packed {
        logic   valid;
        cause_t cause;
    } irq_req_t;

    typedef struct packed {
        logic   take;
        logic   ret;
        xlen_t  epc;
        cause_t cause;
    } trap_update_t;

    typedef enum logic {
        TRAP_IDLE,
        TRAP_PENDING
    } trap_state_t;

endpackage

// ==== trap_unit.sv ====
module trap_unit
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  csr_req_t csr_req,
    output xlen_t    csr_rdata,
    input  sys_op_t  sys_op,
    input  xlen_t    pc,
    input  irq_vec_t irq_lines,
    input  logic     pc_written,
    output logic     trap_pending,
    output logic     redirect_is_irq,
    output xlen_t    redirect_vector
);

    csr_view_t    csr_view;
    irq_vec_t     mip_bits;
    irq_req_t     irq_req;
    trap_update_t trap_update;

    csr_regs u_csr_regs (
        .clock       (clock),
        .reset       (reset),
        .csr_req     (csr_req),
        .mip_bits    (mip_bits),
        .trap_update (trap_update),
        .csr_rdata   (csr_rdata),
        .csr_view    (csr_view)
    );

    // interrupt front end
    irq_sync_arbiter u_irq_sync_arbiter (
        .clock     (clock),
        .reset     (reset),
        .irq_lines (irq_lines),
        .csr_view  (csr_view),
        .mip_bits  (mip_bits),
        .irq_req   (irq_req)
    );

    trap_ctrl u_trap_ctrl (
        .clock           (clock),
        .reset           (reset),
        .sys_op          (sys_op),
        .pc              (pc),
        .irq_req         (irq_req),
        .csr_view        (csr_view),
        .pc_written      (pc_written),
        .trap_update     (trap_update),
        .trap_pending    (trap_pending),
        .redirect_is_irq (redirect_is_irq),
        .redirect_vector (redirect_vector)
    );

endmodule

// ==== trap_unit_assert.sv ====
module trap_unit_assert
    import trap_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input trap_update_t trap_update,
    input logic         trap_pending,
    input logic         pc_written
);

    // one strobe at a time
    take_ret_exclusive: assert property (
        @(posedge clock) disable iff (!reset)
        !(trap_update.take && trap_update.ret)
    ) else $error("trap take and mret restore strobed in the same cycle");

    no_strobe_while_pending: assert property (
        @(posedge clock) disable iff (!reset)
        trap_pending |-> !(trap_update.take || trap_update.ret)
    ) else $error("trap strobe fired while a trap was still pending");

    // pending drops only on the edge after the core loaded its pc
    pending_release: assert property (
        @(posedge clock) disable iff (!reset)
        $fell(trap_pending) |-> $past(pc_written)
    ) else $error("trap_pending fell without pc_written");

endmodule

bind trap_ctrl trap_unit_assert u_trap_unit_assert (
    .clock        (clock),
    .reset        (reset),
    .trap_update  (trap_update),
    .trap_pending (trap_pending),
    .pc_written   (pc_written)
);
